//--- common/fetch_if.sv
`default_nettype none

`include "rv_config.svh"

interface fetch_if;

	logic                 valid;
	logic [`RV_XLEN-1:0]  pc;
	logic [`RV_XLEN-1:0]  inst;
	// decode holds fetch while a source is still in flight
	logic                 stall;

	modport fetch (output valid, output pc, output inst, input stall);

	modport decode (input valid, input pc, input inst, output stall);

endinterface

`default_nettype wire

//--- common/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// datapath width
`define RV_XLEN 32

// register number width, 32 architectural registers
`define RV_REG_ADDR_W 5

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// memory-mapped LED register
`define RV_LED_ADDR 32'h0000_1000
`define RV_LED_W 4

`endif

//--- common/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

	typedef enum logic [6:0] {
		OPC_OP    = 7'b0110011,
		OPC_OPIMM = 7'b0010011,
		OPC_LUI   = 7'b0110111,
		OPC_LOAD  = 7'b0000011,
		OPC_STORE = 7'b0100011
	} opcode_e;

	// arithmetic group, shared by OP and OP-IMM
	typedef enum logic [2:0] {
		F3_ADD_SUB = 3'b000,
		F3_SLL     = 3'b001,
		F3_SLT     = 3'b010,
		F3_SLTU    = 3'b011,
		F3_XOR     = 3'b100,
		F3_SRL_SRA = 3'b101,
		F3_OR      = 3'b110,
		F3_AND     = 3'b111
	} funct3_e;

	// only word width is kept for LOAD and STORE
	localparam logic [2:0] F3_WORD = 3'b010;

	// funct7 selects SUB and SRA/SRAI
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_PASS_B
	} alu_op_e;

endpackage

`default_nettype wire

//--- common/rv_pipe_pkg.sv
`default_nettype none

`include "rv_config.svh"

package rv_pipe_pkg;

	// decode to execute
	typedef struct packed {
		logic                       valid;
		rv_isa_pkg::alu_op_e        alu_op;
		logic [`RV_XLEN-1:0]        operand_a;
		logic [`RV_XLEN-1:0]        operand_b;
		logic [`RV_XLEN-1:0]        store_data;
		logic [`RV_REG_ADDR_W-1:0]  rd_num;
		logic                       reg_write;
		logic                       mem_read;
		logic                       mem_write;
	} id_ex_t;

	// execute to memory
	typedef struct packed {
		logic                       valid;
		logic [`RV_XLEN-1:0]        alu_result;
		logic [`RV_XLEN-1:0]        store_data;
		logic [`RV_REG_ADDR_W-1:0]  rd_num;
		logic                       reg_write;
		logic                       mem_read;
		logic                       mem_write;
	} ex_mem_t;

	// memory/write-back register, also the register file write port
	typedef struct packed {
		logic                       we;
		logic [`RV_REG_ADDR_W-1:0]  rd_num;
		logic [`RV_XLEN-1:0]        value;
	} wb_t;

endpackage

`default_nettype wire

//--- decode/decode_unit.sv
`default_nettype none

`include "rv_config.svh"

module decode_unit (
	input  wire logic                 i_clk,
	input  wire logic                 i_rst,
	fetch_if.decode                   f,
	input  wire rv_pipe_pkg::wb_t     i_wb,
	input  wire rv_pipe_pkg::ex_mem_t i_ex_mem,
	output rv_pipe_pkg::id_ex_t       o_id_ex
);

	logic [`RV_XLEN-1:0]        rf [1:(1 << `RV_REG_ADDR_W)-1];
	logic [`RV_XLEN-1:0]        inst;
	rv_isa_pkg::opcode_e        opcode;
	rv_isa_pkg::funct3_e        funct3;
	logic [6:0]                 funct7;
	logic [`RV_REG_ADDR_W-1:0]  rs1;
	logic [`RV_REG_ADDR_W-1:0]  rs2;
	logic [`RV_XLEN-1:0]        imm_i;
	logic [`RV_XLEN-1:0]        imm_s;
	logic [`RV_XLEN-1:0]        imm_u;
	logic                       is_imm;
	rv_isa_pkg::alu_op_e        arith_op;
	logic                       arith_ok;
	logic                       use_rs1;
	logic                       use_rs2;
	logic                       stall;
	rv_pipe_pkg::id_ex_t        dec;

	// x0 reads zero, a same-cycle write-back is passed straight through
	function automatic logic [`RV_XLEN-1:0] rf_read(input logic [`RV_REG_ADDR_W-1:0] addr);
		logic [`RV_XLEN-1:0] val;
		if (addr == '0) begin
			val = '0;
		end else if (i_wb.we && i_wb.rd_num == addr) begin
			val = i_wb.value;
		end else begin
			val = rf[addr];
		end
		return val;
	endfunction

	// producer still in execute or memory
	function automatic logic in_flight(input logic [`RV_REG_ADDR_W-1:0] addr);
		return addr != '0 &&
			((o_id_ex.valid && o_id_ex.reg_write && o_id_ex.rd_num == addr) ||
			(i_ex_mem.valid && i_ex_mem.reg_write && i_ex_mem.rd_num == addr));
	endfunction

	always_ff @(posedge i_clk) begin
		if (i_wb.we && i_wb.rd_num != '0) begin
			rf[i_wb.rd_num] <= i_wb.value;
		end
	end

	assign inst = f.inst;
	assign opcode = rv_isa_pkg::opcode_e'(inst[6:0]);
	assign funct3 = rv_isa_pkg::funct3_e'(inst[14:12]);
	assign funct7 = inst[31:25];
	assign rs1 = inst[19:15];
	assign rs2 = inst[24:20];
	assign imm_i = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};
	assign imm_s = {{(`RV_XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_u = {inst[31:12], 12'b0};
	assign is_imm = opcode == rv_isa_pkg::OPC_OPIMM;

	always_comb begin
		arith_op = rv_isa_pkg::ALU_ADD;
		arith_ok = is_imm || funct7 == rv_isa_pkg::F7_BASE;
		case (funct3)
			rv_isa_pkg::F3_ADD_SUB: begin
				if (!is_imm && funct7 == rv_isa_pkg::F7_ALT) begin
					arith_op = rv_isa_pkg::ALU_SUB;
					arith_ok = 1'b1;
				end
			end
			rv_isa_pkg::F3_SLL: begin
				arith_op = rv_isa_pkg::ALU_SLL;
				arith_ok = funct7 == rv_isa_pkg::F7_BASE;
			end
			rv_isa_pkg::F3_SLT: arith_op = rv_isa_pkg::ALU_SLT;
			rv_isa_pkg::F3_SLTU: arith_op = rv_isa_pkg::ALU_SLTU;
			rv_isa_pkg::F3_XOR: arith_op = rv_isa_pkg::ALU_XOR;
			rv_isa_pkg::F3_SRL_SRA: begin
				// shift immediates carry funct7 in imm[11:5]
				arith_op = (funct7 == rv_isa_pkg::F7_ALT) ? rv_isa_pkg::ALU_SRA
					: rv_isa_pkg::ALU_SRL;
				arith_ok = funct7 == rv_isa_pkg::F7_ALT || funct7 == rv_isa_pkg::F7_BASE;
			end
			rv_isa_pkg::F3_OR: arith_op = rv_isa_pkg::ALU_OR;
			rv_isa_pkg::F3_AND: arith_op = rv_isa_pkg::ALU_AND;
		endcase
	end

	always_comb begin
		dec = '0;
		dec.valid = f.valid;
		dec.alu_op = rv_isa_pkg::ALU_ADD;
		dec.operand_a = rf_read(rs1);
		dec.operand_b = rf_read(rs2);
		dec.store_data = rf_read(rs2);
		dec.rd_num = inst[11:7];
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		// anything unrecognised passes down as a no-op
		if (f.valid) begin
			case (opcode)
				rv_isa_pkg::OPC_OP: begin
					use_rs1 = 1'b1;
					use_rs2 = 1'b1;
					dec.alu_op = arith_op;
					dec.reg_write = arith_ok;
				end
				rv_isa_pkg::OPC_OPIMM: begin
					use_rs1 = 1'b1;
					dec.alu_op = arith_op;
					dec.operand_b = imm_i;
					dec.reg_write = arith_ok;
				end
				rv_isa_pkg::OPC_LUI: begin
					dec.alu_op = rv_isa_pkg::ALU_PASS_B;
					dec.operand_b = imm_u;
					dec.reg_write = 1'b1;
				end
				rv_isa_pkg::OPC_LOAD: begin
					use_rs1 = 1'b1;
					dec.operand_b = imm_i;
					dec.mem_read = inst[14:12] == rv_isa_pkg::F3_WORD;
					dec.reg_write = inst[14:12] == rv_isa_pkg::F3_WORD;
				end
				rv_isa_pkg::OPC_STORE: begin
					use_rs1 = 1'b1;
					use_rs2 = 1'b1;
					dec.operand_b = imm_s;
					dec.mem_write = inst[14:12] == rv_isa_pkg::F3_WORD;
				end
				default: begin
					dec.reg_write = 1'b0;
				end
			endcase
		end
		dec.reg_write = dec.reg_write && dec.rd_num != '0;
	end

	assign stall = (use_rs1 && in_flight(rs1)) || (use_rs2 && in_flight(rs2));
	assign f.stall = stall;

	// a stalled instruction leaves a bubble behind
	always_ff @(posedge i_clk) begin
		if (i_rst || stall) begin
			o_id_ex.valid <= 1'b0;
			o_id_ex.reg_write <= 1'b0;
			o_id_ex.mem_read <= 1'b0;
			o_id_ex.mem_write <= 1'b0;
		end else begin
			o_id_ex <= dec;
		end
	end

endmodule

`default_nettype wire

//--- execute/execute_unit.sv
`default_nettype none

`include "rv_config.svh"

module execute_unit (
	input  wire logic                 i_clk,
	input  wire logic                 i_rst,
	input  wire rv_pipe_pkg::id_ex_t  i_id_ex,
	output rv_pipe_pkg::ex_mem_t      o_ex_mem
);

	logic [`RV_XLEN-1:0]  a;
	logic [`RV_XLEN-1:0]  b;
	logic [4:0]           shamt;
	logic [`RV_XLEN-1:0]  result;

	assign a = i_id_ex.operand_a;
	assign b = i_id_ex.operand_b;
	assign shamt = b[4:0];

	always_comb begin
		case (i_id_ex.alu_op)
			rv_isa_pkg::ALU_ADD: result = a + b;
			rv_isa_pkg::ALU_SUB: result = a - b;
			rv_isa_pkg::ALU_AND: result = a & b;
			rv_isa_pkg::ALU_OR: result = a | b;
			rv_isa_pkg::ALU_XOR: result = a ^ b;
			rv_isa_pkg::ALU_SLT: begin
				result = {{(`RV_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			end
			rv_isa_pkg::ALU_SLTU: result = {{(`RV_XLEN-1){1'b0}}, a < b};
			rv_isa_pkg::ALU_SLL: result = a << shamt;
			rv_isa_pkg::ALU_SRL: result = a >> shamt;
			rv_isa_pkg::ALU_SRA: result = $unsigned($signed(a) >>> shamt);
			// LUI just carries the U immediate
			rv_isa_pkg::ALU_PASS_B: result = b;
			default: result = '0;
		endcase
	end

	always_ff @(posedge i_clk) begin
		o_ex_mem.alu_result <= result;
		o_ex_mem.store_data <= i_id_ex.store_data;
		o_ex_mem.rd_num <= i_id_ex.rd_num;
		if (i_rst) begin
			o_ex_mem.valid <= 1'b0;
			o_ex_mem.reg_write <= 1'b0;
			o_ex_mem.mem_read <= 1'b0;
			o_ex_mem.mem_write <= 1'b0;
		end else begin
			o_ex_mem.valid <= i_id_ex.valid;
			o_ex_mem.reg_write <= i_id_ex.valid && i_id_ex.reg_write;
			o_ex_mem.mem_read <= i_id_ex.valid && i_id_ex.mem_read;
			o_ex_mem.mem_write <= i_id_ex.valid && i_id_ex.mem_write;
		end
	end

endmodule

`default_nettype wire

//--- fetch/fetch_unit.sv
`default_nettype none

`include "rv_config.svh"

module fetch_unit (
	input  wire logic                 i_clk,
	input  wire logic                 i_rst,
	output logic [`RV_XLEN-1:0]       o_imem_addr,
	input  wire logic [`RV_XLEN-1:0]  i_imem_data,
	fetch_if.fetch                    f
);

	logic [`RV_XLEN-1:0] pc;

	assign o_imem_addr = pc;

	// no branches, so the PC only steps forward
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			pc <= `RV_RESET_PC;
		end else if (!f.stall) begin
			pc <= pc + `RV_XLEN'(4);
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			f.valid <= 1'b0;
		end else if (!f.stall) begin
			f.valid <= 1'b1;
		end
	end

	// fetch/decode register, held during a stall
	always_ff @(posedge i_clk) begin
		if (!f.stall) begin
			f.pc <= pc;
			f.inst <= i_imem_data;
		end
	end

endmodule

`default_nettype wire

//--- src/mem_writeback_unit.sv
`default_nettype none

`include "rv_config.svh"

module mem_writeback_unit (
	input  wire logic                  i_clk,
	input  wire logic                  i_rst,
	input  wire rv_pipe_pkg::ex_mem_t  i_ex_mem,
	output logic [`RV_XLEN-1:0]        o_dmem_addr,
	output logic [`RV_XLEN-1:0]        o_dmem_wdata,
	output logic                       o_dmem_we,
	output logic                       o_dmem_re,
	input  wire logic [`RV_XLEN-1:0]   i_dmem_rdata,
	output logic [`RV_LED_W-1:0]       o_leds,
	output rv_pipe_pkg::wb_t           o_wb
);

	// bus is driven straight from the execute/memory register
	assign o_dmem_addr = i_ex_mem.alu_result;
	assign o_dmem_wdata = i_ex_mem.store_data;
	assign o_dmem_we = i_ex_mem.valid && i_ex_mem.mem_write;
	assign o_dmem_re = i_ex_mem.valid && i_ex_mem.mem_read;

	// LED store still goes out on the bus as well
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_leds <= '0;
		end else if (o_dmem_we && o_dmem_addr == `RV_LED_ADDR) begin
			o_leds <= o_dmem_wdata[`RV_LED_W-1:0];
		end
	end

	always_ff @(posedge i_clk) begin
		o_wb.rd_num <= i_ex_mem.rd_num;
		o_wb.value <= i_ex_mem.mem_read ? i_dmem_rdata : i_ex_mem.alu_result;
		if (i_rst) begin
			o_wb.we <= 1'b0;
		end else begin
			o_wb.we <= i_ex_mem.valid && i_ex_mem.reg_write && i_ex_mem.rd_num != '0;
		end
	end

endmodule

`default_nettype wire

//--- src/rv_core.sv
`default_nettype none

`include "rv_config.svh"

module rv_core (
	input  wire logic                 i_clk,
	input  wire logic                 i_rst,
	output logic [`RV_XLEN-1:0]       o_imem_addr,
	input  wire logic [`RV_XLEN-1:0]  i_imem_data,
	output logic [`RV_XLEN-1:0]       o_dmem_addr,
	output logic [`RV_XLEN-1:0]       o_dmem_wdata,
	output logic                      o_dmem_we,
	output logic                      o_dmem_re,
	input  wire logic [`RV_XLEN-1:0]  i_dmem_rdata,
	output logic [`RV_LED_W-1:0]      o_leds
);

	fetch_if fif ();

	rv_pipe_pkg::id_ex_t   id_ex;
	rv_pipe_pkg::ex_mem_t  ex_mem;
	rv_pipe_pkg::wb_t      wb;

	fetch_unit u_fetch (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.o_imem_addr (o_imem_addr),
		.i_imem_data (i_imem_data),
		.f           (fif.fetch)
	);

	// hazard check sees ex_mem, write-back comes in through wb
	decode_unit u_decode (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.f        (fif.decode),
		.i_wb     (wb),
		.i_ex_mem (ex_mem),
		.o_id_ex  (id_ex)
	);

	execute_unit u_execute (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_id_ex  (id_ex),
		.o_ex_mem (ex_mem)
	);

	mem_writeback_unit u_mem_wb (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_ex_mem     (ex_mem),
		.o_dmem_addr  (o_dmem_addr),
		.o_dmem_wdata (o_dmem_wdata),
		.o_dmem_we    (o_dmem_we),
		.o_dmem_re    (o_dmem_re),
		.i_dmem_rdata (i_dmem_rdata),
		.o_leds       (o_leds),
		.o_wb         (wb)
	);

endmodule

`default_nettype wire

//--- tb.f
+incdir+common
+incdir+verification
common/rv_isa_pkg.sv
common/rv_pipe_pkg.sv
common/fetch_if.sv
fetch/fetch_unit.sv
decode/decode_unit.sv
execute/execute_unit.sv
src/mem_writeback_unit.sv
src/rv_core.sv
verification/tb_rv_core.sv

//--- verification/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// ADDI x0, x0, 0
localparam logic [31:0] NOP = 32'h0000_0013;
localparam logic [31:0] RESULT_BASE = 32'h0000_0100;
localparam logic [31:0] LOAD_ADDR = 32'h0000_0200;
localparam logic [31:0] LED_ADDR = `RV_LED_ADDR;

function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
	input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
	return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP};
endfunction

function automatic logic [31:0] i_type(input logic [2:0] f3, input logic [4:0] rd,
	input logic [4:0] rs1, input logic [11:0] imm);
	return {imm, rs1, f3, rd, rv_isa_pkg::OPC_OPIMM};
endfunction

function automatic logic [31:0] lw_inst(input logic [4:0] rd, input logic [4:0] rs1,
	input logic [11:0] imm);
	return {imm, rs1, rv_isa_pkg::F3_WORD, rd, rv_isa_pkg::OPC_LOAD};
endfunction

function automatic logic [31:0] sw_inst(input logic [4:0] rs2, input logic [4:0] rs1,
	input logic [11:0] imm);
	return {imm[11:5], rs2, rs1, rv_isa_pkg::F3_WORD, imm[4:0], rv_isa_pkg::OPC_STORE};
endfunction

function automatic logic [31:0] u_type(input logic [4:0] rd, input logic [19:0] imm);
	return {imm, rd, rv_isa_pkg::OPC_LUI};
endfunction

function automatic logic [31:0] result_addr(input int k);
	return RESULT_BASE + 32'(4 * k);
endfunction

task automatic clear_program();
	for (int i = 0; i < 64; i++) begin
		prog[i] = NOP;
	end
	prog_len = 0;
endtask

task automatic emit(input logic [31:0] inst);
	prog[prog_len] = inst;
	prog_len++;
endtask

// LUI then ADDI with the upper part rounded for the sign of the low 12 bits
task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
	logic [31:0] upper;
	upper = (value + 32'h800) >> 12;
	emit(u_type(rd, upper[19:0]));
	emit(i_type(rv_isa_pkg::F3_ADD_SUB, rd, rd, value[11:0]));
endtask

task automatic store_result(input logic [4:0] rs, input int k);
	emit(sw_inst(rs, 5'd0, 12'(result_addr(k))));
endtask

task automatic reg_ops_program(input logic [31:0] a, input logic [31:0] b);
	clear_program();
	load_const(5'd1, a);
	load_const(5'd2, b);
	emit(r_type(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_ADD_SUB, 5'd3, 5'd1, 5'd2));
	emit(r_type(rv_isa_pkg::F7_ALT, rv_isa_pkg::F3_ADD_SUB, 5'd4, 5'd1, 5'd2));
	emit(r_type(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_AND, 5'd5, 5'd1, 5'd2));
	emit(r_type(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_OR, 5'd6, 5'd1, 5'd2));
	emit(r_type(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_XOR, 5'd7, 5'd1, 5'd2));
	emit(r_type(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_SLT, 5'd8, 5'd1, 5'd2));
	emit(r_type(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_SLTU, 5'd9, 5'd1, 5'd2));
	emit(r_type(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_SLL, 5'd10, 5'd1, 5'd2));
	emit(r_type(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_SRL_SRA, 5'd11, 5'd1, 5'd2));
	emit(r_type(rv_isa_pkg::F7_ALT, rv_isa_pkg::F3_SRL_SRA, 5'd12, 5'd1, 5'd2));
	for (int k = 0; k < 10; k++) begin
		store_result(5'(3 + k), k);
	end
endtask

task automatic imm_ops_program(input logic [31:0] a, input logic [11:0] imm,
	input logic [4:0] sh, input logic [19:0] u);
	clear_program();
	load_const(5'd1, a);
	emit(i_type(rv_isa_pkg::F3_ADD_SUB, 5'd3, 5'd1, imm));
	emit(i_type(rv_isa_pkg::F3_AND, 5'd4, 5'd1, imm));
	emit(i_type(rv_isa_pkg::F3_OR, 5'd5, 5'd1, imm));
	emit(i_type(rv_isa_pkg::F3_XOR, 5'd6, 5'd1, imm));
	emit(i_type(rv_isa_pkg::F3_SLT, 5'd7, 5'd1, imm));
	emit(i_type(rv_isa_pkg::F3_SLTU, 5'd8, 5'd1, imm));
	emit(i_type(rv_isa_pkg::F3_SLL, 5'd9, 5'd1, {7'b0, sh}));
	emit(i_type(rv_isa_pkg::F3_SRL_SRA, 5'd10, 5'd1, {7'b0, sh}));
	emit(i_type(rv_isa_pkg::F3_SRL_SRA, 5'd11, 5'd1, {rv_isa_pkg::F7_ALT, sh}));
	emit(u_type(5'd12, u));
	// writing x0 must leave it reading zero
	emit(i_type(rv_isa_pkg::F3_ADD_SUB, 5'd0, 5'd1, imm));
	for (int k = 0; k < 10; k++) begin
		store_result(5'(3 + k), k);
	end
	store_result(5'd0, 10);
endtask

task automatic dep_chain_program(input logic [5:0][11:0] imms);
	clear_program();
	emit(i_type(rv_isa_pkg::F3_ADD_SUB, 5'd1, 5'd0, imms[0]));
	for (int k = 1; k < 6; k++) begin
		emit(i_type(rv_isa_pkg::F3_ADD_SUB, 5'd1, 5'd1, imms[k]));
	end
	emit(r_type(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_ADD_SUB, 5'd1, 5'd1, 5'd1));
	store_result(5'd1, 0);
endtask

task automatic load_use_program(input logic [11:0] k);
	clear_program();
	emit(i_type(rv_isa_pkg::F3_ADD_SUB, 5'd2, 5'd0, k));
	emit(lw_inst(5'd1, 5'd0, LOAD_ADDR[11:0]));
	emit(r_type(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_ADD_SUB, 5'd3, 5'd1, 5'd2));
	store_result(5'd3, 0);
endtask

task automatic led_program(input logic [11:0] val);
	clear_program();
	emit(i_type(rv_isa_pkg::F3_ADD_SUB, 5'd1, 5'd0, val));
	emit(u_type(5'd2, LED_ADDR[31:12]));
	emit(sw_inst(5'd1, 5'd2, LED_ADDR[11:0]));
endtask

`endif

//--- verification/tb_rv_core.sv
`default_nettype none

`include "rv_config.svh"

module tb_rv_core;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 40;
	localparam int RUN_CYCLES = 120;
	localparam int WATCHDOG_NS = 5 * 130 * CLK_PERIOD + 50 * CLK_PERIOD;

	logic         i_clk;
	logic         i_rst;
	logic [31:0]  o_imem_addr;
	logic [31:0]  i_imem_data;
	logic [31:0]  o_dmem_addr;
	logic [31:0]  o_dmem_wdata;
	logic         o_dmem_we;
	logic         o_dmem_re;
	logic [31:0]  i_dmem_rdata;
	logic [3:0]   o_leds;

	logic [31:0]  prog [0:63];
	int           prog_len;
	logic [31:0]  dmem [0:255];
	logic [31:0]  exp_addr [$];
	logic [31:0]  exp_data [$];
	logic [31:0]  got_addr [$];
	logic [31:0]  got_data [$];
	logic [31:0]  exp_raddr [$];
	logic [31:0]  got_raddr [$];
	int           checks;
	int           errors;
	int           errors_at_start;
	int           tests_done;
	integer       seed;

	`include "tb_programs.svh"

	rv_core dut (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.o_imem_addr  (o_imem_addr),
		.i_imem_data  (i_imem_data),
		.o_dmem_addr  (o_dmem_addr),
		.o_dmem_wdata (o_dmem_wdata),
		.o_dmem_we    (o_dmem_we),
		.o_dmem_re    (o_dmem_re),
		.i_dmem_rdata (i_dmem_rdata),
		.o_leds       (o_leds)
	);

	always #(CLK_PERIOD / 2) i_clk = ~i_clk;

	function automatic logic [31:0] fetch_word(input logic [31:0] addr);
		if (addr[31:2] < 64) begin
			return prog[addr[7:2]];
		end
		return NOP;
	endfunction

	// memory models driven on the falling edge
	always @(negedge i_clk) begin
		if (o_dmem_we === 1'b1) begin
			dmem[o_dmem_addr[9:2]] = o_dmem_wdata;
		end
		i_imem_data = fetch_word(o_imem_addr);
		i_dmem_rdata = dmem[o_dmem_addr[9:2]];
	end

	function automatic logic [31:0] sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	task automatic fill_data_memory();
		logic [31:0] addr;
		for (int i = 0; i < 256; i++) begin
			addr = 32'(i * 4);
			dmem[i] = {~addr[15:0], addr[15:0]};
		end
	endtask

	task automatic reset_dut();
		@(negedge i_clk);
		i_rst = 1'b1;
		repeat (2) @(negedge i_clk);
		i_rst = 1'b0;
		exp_addr.delete();
		exp_data.delete();
		exp_raddr.delete();
	endtask

	task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	task automatic expect_load(input logic [31:0] addr);
		exp_raddr.push_back(addr);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic run_program();
		got_addr.delete();
		got_data.delete();
		got_raddr.delete();
		repeat (RUN_CYCLES) begin
			@(negedge i_clk);
			if (o_dmem_we === 1'b1) begin
				got_addr.push_back(o_dmem_addr);
				got_data.push_back(o_dmem_wdata);
			end
			if (o_dmem_re === 1'b1) begin
				got_raddr.push_back(o_dmem_addr);
			end
		end
	endtask

	task automatic finish_test(input string name);
		int n;
		n = (exp_addr.size() > got_addr.size()) ? exp_addr.size() : got_addr.size();
		for (int i = 0; i < n; i++) begin
			if (i >= got_addr.size()) begin
				checks++;
				errors++;
				$display("%s: store %0d to %h never happened", name, i, exp_addr[i]);
			end else if (i >= exp_addr.size()) begin
				checks++;
				errors++;
				$display("%s: unexpected extra store to %h", name, got_addr[i]);
			end else begin
				check_value($sformatf("o_dmem_addr (store %0d)", i), got_addr[i], exp_addr[i]);
				check_value($sformatf("o_dmem_wdata (store %0d)", i), got_data[i], exp_data[i]);
			end
		end
		if (got_raddr.size() != exp_raddr.size()) begin
			checks++;
			errors++;
			$display("%s: %0d loads seen where %0d were expected", name,
				got_raddr.size(), exp_raddr.size());
		end else begin
			for (int i = 0; i < got_raddr.size(); i++) begin
				check_value($sformatf("o_dmem_addr (load %0d)", i), got_raddr[i],
					exp_raddr[i]);
			end
		end
		tests_done++;
		$display("test %s finished, %0d errors", name, errors - errors_at_start);
		errors_at_start = errors;
	endtask

	task automatic reg_reg_test();
		logic [31:0] a;
		logic [31:0] b;
		logic [4:0] sh;
		a = $random(seed);
		b = $random(seed);
		sh = b[4:0];
		reg_ops_program(a, b);
		fill_data_memory();
		reset_dut();
		expect_store(result_addr(0), a + b);
		expect_store(result_addr(1), a - b);
		expect_store(result_addr(2), a & b);
		expect_store(result_addr(3), a | b);
		expect_store(result_addr(4), a ^ b);
		expect_store(result_addr(5), ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
		expect_store(result_addr(6), (a < b) ? 32'd1 : 32'd0);
		expect_store(result_addr(7), a << sh);
		expect_store(result_addr(8), a >> sh);
		expect_store(result_addr(9), 32'($signed(a) >>> sh));
		run_program();
		finish_test("reg_reg");
	endtask

	task automatic reg_imm_test();
		logic [31:0] a;
		logic [31:0] r;
		logic [31:0] simm;
		logic [11:0] imm;
		logic [4:0] sh;
		logic [19:0] u;
		a = $random(seed);
		r = $random(seed);
		imm = r[11:0];
		sh = r[16:12];
		u = 20'($random(seed));
		simm = sext12(imm);
		imm_ops_program(a, imm, sh, u);
		fill_data_memory();
		reset_dut();
		expect_store(result_addr(0), a + simm);
		expect_store(result_addr(1), a & simm);
		expect_store(result_addr(2), a | simm);
		expect_store(result_addr(3), a ^ simm);
		expect_store(result_addr(4), ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0);
		expect_store(result_addr(5), (a < simm) ? 32'd1 : 32'd0);
		expect_store(result_addr(6), a << sh);
		expect_store(result_addr(7), a >> sh);
		expect_store(result_addr(8), 32'($signed(a) >>> sh));
		expect_store(result_addr(9), {u, 12'b0});
		expect_store(result_addr(10), 32'd0);
		run_program();
		finish_test("reg_imm");
	endtask

	task automatic dep_chain_test();
		logic [5:0][11:0] imms;
		logic [31:0] sum;
		sum = '0;
		for (int k = 0; k < 6; k++) begin
			imms[k] = 12'($random(seed));
			sum = sum + sext12(imms[k]);
		end
		dep_chain_program(imms);
		fill_data_memory();
		reset_dut();
		expect_store(result_addr(0), sum + sum);
		run_program();
		finish_test("dep_chain");
	endtask

	task automatic load_use_test();
		logic [31:0] word;
		logic [11:0] k;
		word = $random(seed);
		k = 12'($random(seed));
		load_use_program(k);
		fill_data_memory();
		dmem[LOAD_ADDR[9:2]] = word;
		reset_dut();
		expect_load(LOAD_ADDR);
		expect_store(result_addr(0), word + sext12(k));
		run_program();
		finish_test("load_use");
	endtask

	task automatic led_test();
		logic [11:0] val;
		val = 12'($random(seed));
		// nonzero low bits so the LED update is visible
		if (val[3:0] == 4'h0) begin
			val[3:0] = 4'ha;
		end
		led_program(val);
		fill_data_memory();
		reset_dut();
		check_value("o_leds", 32'(o_leds), 32'h0);
		check_value("o_imem_addr", o_imem_addr, `RV_RESET_PC);
		expect_store(LED_ADDR, sext12(val));
		run_program();
		check_value("o_leds", 32'(o_leds), 32'(val[3:0]));
		// a second reset clears the lit LEDs
		i_rst = 1'b1;
		repeat (2) @(negedge i_clk);
		i_rst = 1'b0;
		check_value("o_leds", 32'(o_leds), 32'h0);
		finish_test("leds");
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog timeout after %0d ns, tests did not finish", WATCHDOG_NS);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		i_clk = 1'b0;
		i_rst = 1'b1;
		i_imem_data = NOP;
		i_dmem_rdata = '0;
		seed = 32'ha740;
		checks = 0;
		errors = 0;
		errors_at_start = 0;
		tests_done = 0;
		clear_program();
		fill_data_memory();
		reg_reg_test();
		reg_imm_test();
		dep_chain_test();
		load_use_test();
		led_test();
		$display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
